//--- run_sim.sh
#!/bin/sh
# Builds the store buffer testbench with Verilator 5 and runs it

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert --top-module store_buffer_tb \
    -f store_buffer.f -o store_buffer_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/store_buffer_sim > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
    echo "Simulation run returned status $run_status"
    exit 1
fi

if grep -q "^Simulation passed$" "$LOG"; then
    exit 0
fi
echo "Pass message not found in $LOG"
exit 1

//--- source/stb_controller.sv
// Full flag is sampled one cycle late, so the queue must report full one entry early
module stb_controller (
    input  logic clk,
    input  logic rst_n,
    input  logic store_req,
    input  logic store_w_en,
    input  logic dmem_sel,
    input  logic queue_full,
    output logic queue_wr,
    output logic stb_ack
);

    stb_pkg::stb_state_t state;
    stb_pkg::stb_state_t next_state;
    logic full_ff;      // Registered view of queue_full
    logic store_hit;    // Store aimed at data memory

    assign store_hit = store_req & store_w_en & dmem_sel;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= stb_pkg::SB_IDLE;
            full_ff <= 1'b0;
        end else begin
            state   <= next_state;
            full_ff <= queue_full;
        end
    end

    always_comb begin
        queue_wr   = 1'b0;
        stb_ack    = 1'b0;
        next_state = stb_pkg::SB_IDLE;   // Loads, dropped requests, other selects

        case (state)
            stb_pkg::SB_IDLE,
            stb_pkg::SB_FULL: begin
                stb_ack = 1'b0;
            end
            stb_pkg::SB_WRITE: begin
                stb_ack = 1'b1;          // Acks the write of the previous cycle
            end
            default: begin
                stb_ack = 1'b0;
            end
        endcase

        // Same request decode from every state
        if (store_hit) begin
            if (full_ff) begin
                next_state = stb_pkg::SB_FULL;   // Hold off until space frees
            end else begin
                queue_wr   = 1'b1;
                next_state = stb_pkg::SB_WRITE;
            end
        end
    end

endmodule

//--- source/stb_defines.svh
// Queue depth must be at least 2 so the full flag keeps its one-entry margin
// Register addresses are 1-bit values, one per register
`ifndef STB_DEFINES_SVH
`define STB_DEFINES_SVH

// Store queue geometry
`define STB_DEPTH 4
`define STB_ADDR_W 32
`define STB_DATA_W 32

// Config register map
`define STB_REG_CTRL 1'b0
`define STB_REG_COUNT 1'b1

`endif

//--- source/stb_drain.sv
// One store in flight at a time; mem_ack is taken as a single-cycle pulse
module stb_drain (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                drain_en,
    input  logic                queue_empty,
    input  stb_pkg::stb_entry_t head_entry,
    input  logic                mem_ack,
    output logic                mem_req,
    output stb_pkg::stb_entry_t mem_entry,
    output logic                queue_pop
);

    stb_pkg::drain_state_t state;
    stb_pkg::drain_state_t next_state;
    logic issue;

    assign issue = (state == stb_pkg::DR_IDLE) & drain_en & ~queue_empty;

    always_comb begin
        next_state = state;
        queue_pop  = 1'b0;
        case (state)
            stb_pkg::DR_IDLE: if (issue) next_state = stb_pkg::DR_WAIT;
            stb_pkg::DR_WAIT: begin
                if (mem_ack) begin
                    queue_pop  = 1'b1;       // Head leaves once memory takes it
                    next_state = stb_pkg::DR_IDLE;
                end
            end
            default: next_state = stb_pkg::DR_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= stb_pkg::DR_IDLE;
        end else begin
            state <= next_state;
        end
    end

    // Held copy keeps the bus stable for the whole request
    always_ff @(posedge clk) begin
        if (issue) begin
            mem_entry <= head_entry;
        end
    end

    assign mem_req = (state == stb_pkg::DR_WAIT);

endmodule

//--- source/stb_pkg.sv
// Types shared by the store buffer blocks; widths come from the defines header
`include "stb_defines.svh"

package stb_pkg;

    typedef logic [`STB_ADDR_W-1:0] addr_t;
    typedef logic [`STB_DATA_W-1:0] data_t;
    typedef logic [`STB_DATA_W/8-1:0] mask_t;    // One bit per byte lane
    typedef logic [15:0] count_t;

    // One buffered store as it travels from LSU to memory
    typedef struct packed {
        addr_t addr;
        data_t data;
        mask_t mask;
    } stb_entry_t;

    typedef enum logic [1:0] {
        SB_IDLE  = 2'b00,
        SB_WRITE = 2'b01,
        SB_FULL  = 2'b10
    } stb_state_t;

    typedef enum logic {
        DR_IDLE = 1'b0,
        DR_WAIT = 1'b1
    } drain_state_t;

endpackage

//--- source/stb_queue.sv
// Writer must respect queue_full, there is no overflow guard here
// Pop is only legal while the queue is not empty
module stb_queue (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                queue_wr,
    input  stb_pkg::stb_entry_t store_entry,
    input  logic                queue_pop,
    output stb_pkg::stb_entry_t head_entry,
    output logic                queue_empty,
    output logic                queue_full
);

`include "stb_defines.svh"

    localparam int PTR_W = (`STB_DEPTH > 1) ? $clog2(`STB_DEPTH) : 1;
    localparam int CNT_W = $clog2(`STB_DEPTH + 1);
    localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(`STB_DEPTH - 1);
    localparam logic [CNT_W-1:0] FULL_MARK = CNT_W'(`STB_DEPTH - 1);

    stb_pkg::stb_entry_t entries [`STB_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;     // Entries currently held

    // Storage array
    always_ff @(posedge clk) begin
        if (queue_wr) begin
            entries[wr_ptr] <= store_entry;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (queue_wr) begin
                wr_ptr <= (wr_ptr == LAST_PTR) ? '0 : wr_ptr + 1'b1;
            end
            if (queue_pop) begin
                rd_ptr <= (rd_ptr == LAST_PTR) ? '0 : rd_ptr + 1'b1;
            end

            // Write and pop together leave the count unchanged
            case ({queue_wr, queue_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    assign head_entry  = entries[rd_ptr];
    assign queue_empty = (count == '0);

    // One slot of margin covers the write already in flight
    assign queue_full = (count >= FULL_MARK);

endmodule

//--- source/stb_regs.sv
// Only bit 0 of the control register is kept; the count register ignores writes
module stb_regs (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            cfg_we,
    input  logic            cfg_addr,
    input  stb_pkg::count_t cfg_wdata,
    output stb_pkg::count_t cfg_rdata,
    input  logic            queue_pop,
    output logic            drain_en
);

`include "stb_defines.svh"

    stb_pkg::count_t commit_count;   // Stores handed to memory, wraps

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            drain_en     <= 1'b0;
            commit_count <= '0;
        end else begin
            if (cfg_we && cfg_addr == `STB_REG_CTRL) begin
                drain_en <= cfg_wdata[0];
            end
            if (queue_pop) begin
                commit_count <= commit_count + 1'b1;
            end
        end
    end

    always_comb begin
        cfg_rdata = '0;
        case (cfg_addr)
            `STB_REG_CTRL:  cfg_rdata = stb_pkg::count_t'(drain_en);
            `STB_REG_COUNT: cfg_rdata = commit_count;
            default:        cfg_rdata = '0;
        endcase
    end

endmodule

//--- source/store_buffer.sv
// Store buffer top; config reads are combinational, writes land on the clock edge
module store_buffer (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                store_req,
    input  logic                store_w_en,
    input  logic                dmem_sel,
    input  stb_pkg::stb_entry_t store_entry,
    output logic                stb_ack,
    output logic                mem_req,
    output stb_pkg::stb_entry_t mem_entry,
    input  logic                mem_ack,
    input  logic                cfg_we,
    input  logic                cfg_addr,
    input  stb_pkg::count_t     cfg_wdata,
    output stb_pkg::count_t     cfg_rdata
);

    logic                queue_wr;
    logic                queue_full;
    logic                queue_empty;
    logic                queue_pop;
    logic                drain_en;
    stb_pkg::stb_entry_t head_entry;

    stb_controller u_ctrl (
        .clk, .rst_n, .store_req, .store_w_en, .dmem_sel,
        .queue_full, .queue_wr, .stb_ack
    );

    stb_queue u_queue (
        .clk, .rst_n, .queue_wr, .store_entry, .queue_pop,
        .head_entry, .queue_empty, .queue_full
    );

    stb_drain u_drain (
        .clk, .rst_n, .drain_en, .queue_empty, .head_entry,
        .mem_ack, .mem_req, .mem_entry, .queue_pop
    );

    stb_regs u_regs (
        .clk, .rst_n, .cfg_we, .cfg_addr, .cfg_wdata,
        .cfg_rdata, .queue_pop, .drain_en
    );

endmodule

//--- store_buffer.f
+incdir+source
source/stb_pkg.sv
source/stb_controller.sv
source/stb_queue.sv
source/stb_drain.sv
source/stb_regs.sv
source/store_buffer.sv
testbench/tb_clock.sv
testbench/store_buffer_sva.sv
testbench/store_buffer_tb.sv

//--- testbench/store_buffer_sva.sv
// Bound to the store buffer top; occupancy is rebuilt from the write and pop strobes
module store_buffer_sva (
    input logic                clk,
    input logic                rst_n,
    input logic                queue_wr,
    input logic                queue_pop,
    input logic                stb_ack,
    input logic                mem_req,
    input logic                mem_ack,
    input stb_pkg::stb_entry_t mem_entry
);

`include "stb_defines.svh"

    int occupancy;   // Entries held in the queue

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            occupancy <= 0;
        end else begin
            occupancy <= occupancy + int'(queue_wr) - int'(queue_pop);
        end
    end

    queue_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
        occupancy <= `STB_DEPTH)
        else $error("Store queue holds more than %0d entries", `STB_DEPTH);

    // Request and entry hold until memory acknowledges
    mem_req_stable: assert property (@(posedge clk) disable iff (!rst_n)
        mem_req && !mem_ack |=> mem_req && $stable(mem_entry))
        else $error("mem_req or mem_entry changed before mem_ack");

    ack_follows_write: assert property (@(posedge clk) disable iff (!rst_n)
        stb_ack |-> $past(queue_wr))
        else $error("stb_ack without a queue write in the previous cycle");

endmodule

bind store_buffer store_buffer_sva sva_checks (
    .clk(clk), .rst_n(rst_n), .queue_wr(queue_wr), .queue_pop(queue_pop),
    .stb_ack(stb_ack), .mem_req(mem_req), .mem_ack(mem_ack), .mem_entry(mem_entry)
);

//--- testbench/store_buffer_tb.sv
// Directed tests for the store buffer; memory answers each request in 1 to 3 cycles
// Inputs change and outputs are sampled on the falling edge
module store_buffer_tb;

`include "stb_defines.svh"

    localparam logic [31:0] SEED = 32'h8e3a_c1a4;
    localparam int RAND_CYCLES = 64;
    // Each store drains in at most 5 cycles, so this leaves a wide margin
    localparam int WATCHDOG_CYCLES = 20 * (RAND_CYCLES + 4 * `STB_DEPTH + 20);

    logic clk;
    logic rst_n;
    logic store_req;
    logic store_w_en;
    logic dmem_sel;
    stb_pkg::stb_entry_t store_entry;
    logic stb_ack;
    logic mem_req;
    stb_pkg::stb_entry_t mem_entry;
    logic mem_ack;
    logic cfg_we;
    logic cfg_addr;
    stb_pkg::count_t cfg_wdata;
    stb_pkg::count_t cfg_rdata;

    stb_pkg::stb_entry_t sent_q[$];    // Acked stores still owed to memory
    stb_pkg::stb_entry_t last_entry;   // Driven in the previous cycle
    logic last_hit;
    int ack_count = 0;
    int mem_seen = 0;
    int stim_seed = SEED;
    int delay_seed = SEED;

    tb_clock clock_gen (.clk(clk));

    store_buffer dut (.*);

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Simulation failed");
        $fatal(1, "Run stopped at first error");
    endtask

    task automatic check_bit(input string what, input logic got, input logic exp);
        if (got !== exp) begin
            abort_run($sformatf("Mismatch at %0t: %s expected %b, got %b",
                $time, what, exp, got));
        end
    endtask

    task automatic check_count(input string what, input stb_pkg::count_t got,
                               input stb_pkg::count_t exp);
        if (got !== exp) begin
            abort_run($sformatf("Mismatch at %0t: %s expected %0d, got %0d",
                $time, what, exp, got));
        end
    endtask

    task automatic check_entry(input string what, input stb_pkg::stb_entry_t got,
                               input stb_pkg::stb_entry_t exp);
        if (got !== exp) begin
            abort_run($sformatf("Mismatch at %0t: %s expected %h/%h/%h, got %h/%h/%h",
                $time, what, exp.addr, exp.data, exp.mask, got.addr, got.data, got.mask));
        end
    endtask

    function automatic stb_pkg::stb_entry_t pattern_entry(input int idx);
        stb_pkg::stb_entry_t e;
        e.addr = stb_pkg::addr_t'(32'h0000_4000 + idx * 4);
        e.data = stb_pkg::data_t'(32'hc0de_0000 + idx);
        e.mask = stb_pkg::mask_t'(idx + 1);
        return e;
    endfunction

    // One cycle of LSU traffic; collects the ack for last cycle's store first
    task automatic next_cycle(input logic req, input logic w_en, input logic sel,
                              input stb_pkg::stb_entry_t e);
        @(negedge clk);
        if (stb_ack && !last_hit) begin
            abort_run("stb_ack came without a store request in the previous cycle");
        end
        if (stb_ack) begin
            sent_q.push_back(last_entry);
            ack_count++;
        end
        store_req = req;
        store_w_en = w_en;
        dmem_sel = sel;
        store_entry = e;
        last_entry = e;
        last_hit = req & w_en & sel;
    endtask

    task automatic cfg_write(input logic addr, input stb_pkg::count_t data);
        @(negedge clk);
        cfg_we = 1'b1;
        cfg_addr = addr;
        cfg_wdata = data;
        @(negedge clk);
        cfg_we = 1'b0;
    endtask

    task automatic cfg_read(input logic addr, output stb_pkg::count_t data);
        @(negedge clk);
        cfg_addr = addr;
        @(negedge clk);
        data = cfg_rdata;
    endtask

    // Drain is idle once mem_req stays low for two falling edges in a row
    task automatic wait_drained();
        int quiet;
        quiet = 0;
        while (quiet < 2) begin
            @(negedge clk);
            quiet = mem_req ? 0 : quiet + 1;
        end
    endtask

    task automatic check_reset_state();
        stb_pkg::count_t value;
        check_bit("stb_ack after reset", stb_ack, 1'b0);
        check_bit("mem_req after reset", mem_req, 1'b0);
        cfg_read(`STB_REG_CTRL, value);
        check_count("control register after reset", value, '0);
        cfg_read(`STB_REG_COUNT, value);
        check_count("count register after reset", value, '0);
    endtask

    task automatic fill_paused();
        for (int i = 0; i < `STB_DEPTH + 4; i++) begin
            next_cycle(1'b1, 1'b1, 1'b1, pattern_entry(i));
            // Ack lands one cycle after each of the first STB_DEPTH writes
            check_bit("stb_ack while filling", stb_ack, i > 0 && i <= `STB_DEPTH);
            check_bit("mem_req while paused", mem_req, 1'b0);
        end
        next_cycle(1'b0, 1'b0, 1'b0, '0);
        check_bit("stb_ack with queue full", stb_ack, 1'b0);
    endtask

    task automatic drain_in_order();
        stb_pkg::count_t value;
        cfg_write(`STB_REG_CTRL, 16'd1);
        wait_drained();
        check_count("stores seen by memory", stb_pkg::count_t'(mem_seen),
            stb_pkg::count_t'(`STB_DEPTH));
        cfg_read(`STB_REG_COUNT, value);
        check_count("count register after drain", value, stb_pkg::count_t'(`STB_DEPTH));
    endtask

    task automatic blocked_requests();
        for (int i = 0; i < 6; i++) begin
            next_cycle(1'b1, i[0], ~i[0], pattern_entry(100 + i));   // Load or other select
            check_bit("stb_ack for blocked request", stb_ack, 1'b0);
            check_bit("mem_req for blocked request", mem_req, 1'b0);
        end
        next_cycle(1'b0, 1'b0, 1'b0, '0);
        check_bit("stb_ack after blocked requests", stb_ack, 1'b0);
    endtask

    task automatic random_traffic();
        stb_pkg::stb_entry_t e;
        stb_pkg::count_t value;
        for (int i = 0; i < RAND_CYCLES; i++) begin
            e.addr = $random(stim_seed);
            e.data = $random(stim_seed);
            e.mask = stb_pkg::mask_t'($random(stim_seed));
            next_cycle(($random(stim_seed) & 3) != 0, ($random(stim_seed) & 7) != 0,
                ($random(stim_seed) & 7) != 0, e);
        end
        next_cycle(1'b0, 1'b0, 1'b0, '0);
        wait_drained();
        check_count("stores seen by memory", stb_pkg::count_t'(mem_seen),
            stb_pkg::count_t'(ack_count));
        cfg_read(`STB_REG_COUNT, value);
        check_count("final count register", value, stb_pkg::count_t'(ack_count));
    endtask

    // Memory model: compares each request with the oldest acked store
    initial begin : mem_responder
        int delay;
        mem_ack = 1'b0;
        forever begin
            @(negedge clk);
            mem_ack = 1'b0;
            if (mem_req) begin
                delay = int'($unsigned($random(delay_seed)) % 32'd3);
                repeat (delay) @(negedge clk);
                if (sent_q.size() == 0) begin
                    abort_run("Memory request arrived with no acknowledged store pending");
                end else begin
                    check_entry("mem_entry", mem_entry, sent_q.pop_front());
                    mem_seen++;
                    mem_ack = 1'b1;
                end
            end
        end
    end

    initial begin : watchdog
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        abort_run($sformatf("Timeout: tests did not finish in %0d cycles", WATCHDOG_CYCLES));
    end

    initial begin
        rst_n = 1'b0;
        store_req = 1'b0;
        store_w_en = 1'b0;
        dmem_sel = 1'b0;
        store_entry = '0;
        cfg_we = 1'b0;
        cfg_addr = 1'b0;
        cfg_wdata = '0;
        last_entry = '0;
        last_hit = 1'b0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        check_reset_state();
        fill_paused();
        drain_in_order();
        blocked_requests();
        random_traffic();

        $display("Simulation passed");
        $finish;
    end

endmodule

//--- testbench/tb_clock.sv
// Free-running clock, period 10 time units, starts low
module tb_clock (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

endmodule
